// File: Bender.yml
package:
  name: motor_ctrl

export_include_dirs:
  - .

sources:
  - files:
      - motor_ctrl_pkg.sv
      - spi_byte_slave.sv
      - host_cmd_decoder.sv
      - motor_watchdog.sv
      - bldc_motor.sv
      - motor_ctrl_top.sv
  - target: test
    files:
      - tb_motor_ctrl.sv

// File: bldc_motor.sv
// Six-step hall commutation, high-side PWM and x4 quadrature counter for one motor
`include "motor_ctrl_cfg.svh"

module bldc_motor (
    input  logic                       sysclk,
    input  logic                       watchdog_timer_reset_flag,
    input  logic                       en_i,
    input  motor_ctrl_pkg::duty_t      duty_i,
    input  motor_ctrl_pkg::hall_t      hall_i,
    input  logic                       enc_a_i,
    input  logic                       enc_b_i,
    output logic [2:0]                 phase_h_o,
    output logic [2:0]                 phase_l_o,
    output motor_ctrl_pkg::enc_count_t enc_count_o,
    output logic                       connected_o
);

    motor_ctrl_pkg::duty_t pwm_cnt;
    logic [2:0]            high_sel;
    logic [2:0]            low_sel;
    logic                  low_on;
    logic                  high_on;
    logic                  enc_a_d;
    logic                  enc_b_d;
    logic                  enc_step;
    logic                  enc_up;

    // All-zero and all-one hall codes mean the sensor is unplugged
    assign connected_o = (hall_i != 3'b000) && (hall_i != 3'b111);

    // Phase masks are one-hot {a,b,c}
    always_comb begin
        case (hall_i)
            3'b101: begin
                high_sel = 3'b100;
                low_sel  = 3'b010;
            end
            3'b100: begin
                high_sel = 3'b100;
                low_sel  = 3'b001;
            end
            3'b110: begin
                high_sel = 3'b010;
                low_sel  = 3'b001;
            end
            3'b010: begin
                high_sel = 3'b010;
                low_sel  = 3'b100;
            end
            3'b011: begin
                high_sel = 3'b001;
                low_sel  = 3'b100;
            end
            3'b001: begin
                high_sel = 3'b001;
                low_sel  = 3'b010;
            end
            default: begin
                high_sel = 3'b000;
                low_sel  = 3'b000;
            end
        endcase
    end

    assign low_on    = en_i && (duty_i != '0);
    assign high_on   = low_on && (pwm_cnt < duty_i);
    assign phase_h_o = high_on ? high_sel : 3'b000;
    assign phase_l_o = low_on ? low_sel : 3'b000;

    // One count per edge on either channel, direction from A against old B
    assign enc_step = enc_a_i ^ enc_a_d ^ enc_b_i ^ enc_b_d;
    assign enc_up   = enc_a_i ^ enc_b_d;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            pwm_cnt     <= '0;
            enc_a_d     <= 1'b0;
            enc_b_d     <= 1'b0;
            enc_count_o <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            enc_a_d <= enc_a_i;
            enc_b_d <= enc_b_i;
            if (enc_step) begin
                enc_count_o <= enc_up ? enc_count_o + 1'b1 : enc_count_o - 1'b1;
            end
        end
    end

endmodule

// File: host_cmd_decoder.sv
// Host command decode with transfer buffers, duty registers and motor enable
`include "motor_ctrl_cfg.svh"

module host_cmd_decoder (
    input  logic                       sysclk,
    input  logic                       watchdog_timer_reset_flag,
    input  motor_ctrl_pkg::spi_byte_t  rx_byte_i,
    input  logic                       byte_done_i,
    input  logic                       start_i,
    input  logic                       end_i,
    input  motor_ctrl_pkg::enc_count_t enc_count_i [`MC_NUM_MOTORS],
    input  logic [`MC_NUM_MOTORS-1:0]  hall_conn_i,
    input  motor_ctrl_pkg::wdt_count_t wdt_count_i,
    input  logic                       wdt_tripped_i,
    output motor_ctrl_pkg::spi_byte_t  tx_byte_o,
    output motor_ctrl_pkg::duty_t      duty_o [`MC_NUM_MOTORS],
    output logic                       motors_en_o,
    output logic                       kick_o
);

    localparam motor_ctrl_pkg::spi_byte_t FILL_BYTE = 8'hAA;
    // Watchdog count follows the per-motor byte pairs
    localparam int WDT_BYTE = 2 * `MC_NUM_MOTORS + 1;

    motor_ctrl_pkg::buf_index_t byte_cnt;
    motor_ctrl_pkg::spi_byte_t  req_buf [`MC_BUF_LEN];
    motor_ctrl_pkg::spi_byte_t  res_buf [`MC_BUF_LEN];
    motor_ctrl_pkg::cmd_e       cmd_op;
    logic                       cmd_rd;
    logic                       fill_q;
    logic                       do_update;
    logic                       do_enable;

    assign cmd_rd    = req_buf[0][`MC_BYTE_WIDTH-1];
    assign cmd_op    = motor_ctrl_pkg::cmd_e'(req_buf[0][`MC_BYTE_WIDTH-2:0]);
    assign tx_byte_o = (byte_cnt < `MC_BUF_LEN) ? res_buf[byte_cnt] : FILL_BYTE;

    // Byte count includes the command byte
    assign do_update = end_i && cmd_rd && (cmd_op == motor_ctrl_pkg::CMD_UPDATE_MOTORS)
                       && (byte_cnt == 2 * `MC_NUM_MOTORS + 1);
    assign do_enable = end_i && (cmd_op == motor_ctrl_pkg::CMD_MOTOR_EN) && (byte_cnt == 2);

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            byte_cnt <= '0;
            fill_q   <= 1'b0;
        end else begin
            fill_q <= byte_done_i && (byte_cnt == '0);
            if (start_i) begin
                byte_cnt <= '0;
            end else if (byte_done_i && (byte_cnt != '1)) begin
                // Saturate so long transfers never alias a valid count
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (byte_done_i && (byte_cnt < `MC_BUF_LEN)) begin
            req_buf[byte_cnt] <= rx_byte_i;
        end
    end

    // Status byte tracks live state, the rest is filled once per read command
    always_ff @(posedge sysclk) begin
        res_buf[0] <= {wdt_tripped_i, motors_en_o, 2'b00, hall_conn_i};
        if (fill_q && cmd_rd) begin
            case (cmd_op)
                motor_ctrl_pkg::CMD_UPDATE_MOTORS,
                motor_ctrl_pkg::CMD_ENCODER_COUNT: begin
                    for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
                        res_buf[2*m+1] <= enc_count_i[m][`MC_ENC_WIDTH-1:`MC_BYTE_WIDTH];
                        res_buf[2*m+2] <= enc_count_i[m][`MC_BYTE_WIDTH-1:0];
                    end
                    res_buf[WDT_BYTE]   <= wdt_count_i[`MC_WDT_WIDTH-1:`MC_BYTE_WIDTH];
                    res_buf[WDT_BYTE+1] <= wdt_count_i[`MC_BYTE_WIDTH-1:0];
                    res_buf[WDT_BYTE+2] <= '0;
                end
                motor_ctrl_pkg::CMD_DUTY_CYCLE: begin
                    for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
                        res_buf[2*m+1] <= motor_ctrl_pkg::spi_byte_t'(
                            duty_o[m][`MC_DUTY_WIDTH-1:`MC_BYTE_WIDTH]);
                        res_buf[2*m+2] <= duty_o[m][`MC_BYTE_WIDTH-1:0];
                    end
                    for (int i = WDT_BYTE; i < `MC_BUF_LEN; i++) begin
                        res_buf[i] <= '0;
                    end
                end
                default: begin
                    for (int i = 1; i < `MC_BUF_LEN; i++) begin
                        res_buf[i] <= FILL_BYTE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            motors_en_o <= 1'b0;
            kick_o      <= 1'b0;
            for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
                duty_o[m] <= '0;
            end
        end else begin
            kick_o <= do_update || do_enable;
            if (do_update) begin
                // Low byte first, then the two high bits
                for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
                    duty_o[m] <= {req_buf[2*m+2][`MC_DUTY_WIDTH-`MC_BYTE_WIDTH-1:0],
                                  req_buf[2*m+1]};
                end
                motors_en_o <= 1'b1;
            end else if (do_enable) begin
                motors_en_o <= cmd_rd;
            end
            // Trip overrides any command in the same cycle
            if (wdt_tripped_i) begin
                motors_en_o <= 1'b0;
            end
        end
    end

endmodule

// File: motor_ctrl_cfg.svh
// Motor count, data width, transfer buffer and watchdog size macros
`ifndef MOTOR_CTRL_CFG_SVH
`define MOTOR_CTRL_CFG_SVH

// Number of three-phase motors
`define MC_NUM_MOTORS 4

// Duty cycle and PWM counter width
`define MC_DUTY_WIDTH 10

// Quadrature encoder count width
`define MC_ENC_WIDTH 16

// SPI word width
`define MC_BYTE_WIDTH 8

// Request and response buffer length in bytes
`define MC_BUF_LEN 12

// Watchdog steps once every 2**5 sysclk
`define MC_WDT_PRESCALE_WIDTH 5

// Watchdog step counter width
`define MC_WDT_WIDTH 16

`endif

// File: motor_ctrl_pkg.sv
// Vector typedefs and the host command opcodes
`include "motor_ctrl_cfg.svh"

package motor_ctrl_pkg;

    // One motor duty cycle
    typedef logic [`MC_DUTY_WIDTH-1:0] duty_t;

    // One encoder position count
    typedef logic [`MC_ENC_WIDTH-1:0] enc_count_t;

    // One SPI byte
    typedef logic [`MC_BYTE_WIDTH-1:0] spi_byte_t;

    // Watchdog step count
    typedef logic [`MC_WDT_WIDTH-1:0] wdt_count_t;

    // Hall code ordered {a,b,c}
    typedef logic [2:0] hall_t;

    // Index into the transfer buffers
    typedef logic [$clog2(`MC_BUF_LEN)-1:0] buf_index_t;

    // Opcode in bits 6:0 of the command byte
    typedef enum logic [`MC_BYTE_WIDTH-2:0] {
        CMD_UPDATE_MOTORS = 7'h00,
        CMD_ENCODER_COUNT = 7'h11,
        CMD_DUTY_CYCLE    = 7'h13,
        CMD_MOTOR_EN      = 7'h30
    } cmd_e;

endpackage

// File: motor_ctrl_top.f
+incdir+.
motor_ctrl_pkg.sv
spi_byte_slave.sv
host_cmd_decoder.sv
motor_watchdog.sv
bldc_motor.sv
motor_ctrl_top.sv
tb_motor_ctrl.sv

// File: motor_ctrl_top.sv
// Controller top with input synchronizers, output registers, MISO tri-state and instances
`include "motor_ctrl_cfg.svh"

module motor_ctrl_top (
    input  logic                          sysclk,
    input  logic                          watchdog_timer_reset_flag,
    input  logic [`MC_NUM_MOTORS-1:0]     hall_a_i,
    input  logic [`MC_NUM_MOTORS-1:0]     hall_b_i,
    input  logic [`MC_NUM_MOTORS-1:0]     hall_c_i,
    input  logic [`MC_NUM_MOTORS-1:0]     enc_a_i,
    input  logic [`MC_NUM_MOTORS-1:0]     enc_b_i,
    input  logic                          spi_sck_i,
    input  logic                          spi_mosi_i,
    input  logic                          spi_ncs_i,
    output logic                          spi_miso_o,
    output logic [3*`MC_NUM_MOTORS-1:0]   phase_h_o,
    output logic [3*`MC_NUM_MOTORS-1:0]   phase_l_o
);

    // Five per-motor inputs plus SCK, MOSI and NCS, with NCS at bit 0
    localparam int IN_WIDTH = 5 * `MC_NUM_MOTORS + 3;

    logic [IN_WIDTH-1:0]           in_meta;
    logic [IN_WIDTH-1:0]           in_sync;
    logic [`MC_NUM_MOTORS-1:0]     hall_a_s;
    logic [`MC_NUM_MOTORS-1:0]     hall_b_s;
    logic [`MC_NUM_MOTORS-1:0]     hall_c_s;
    logic [`MC_NUM_MOTORS-1:0]     enc_a_s;
    logic [`MC_NUM_MOTORS-1:0]     enc_b_s;
    logic                          sck_s;
    logic                          mosi_s;
    logic                          ncs_s;
    logic                          miso;
    logic                          miso_q;
    motor_ctrl_pkg::spi_byte_t     rx_byte;
    motor_ctrl_pkg::spi_byte_t     tx_byte;
    logic                          byte_done;
    logic                          spi_start;
    logic                          spi_end;
    motor_ctrl_pkg::duty_t         duty [`MC_NUM_MOTORS];
    motor_ctrl_pkg::enc_count_t    enc_count [`MC_NUM_MOTORS];
    logic [`MC_NUM_MOTORS-1:0]     hall_conn;
    logic                          motors_en;
    logic                          kick;
    motor_ctrl_pkg::wdt_count_t    wdt_count;
    logic                          wdt_tripped;
    logic [3*`MC_NUM_MOTORS-1:0]   phase_h;
    logic [3*`MC_NUM_MOTORS-1:0]   phase_l;

    assign {hall_a_s, hall_b_s, hall_c_s, enc_a_s, enc_b_s, sck_s, mosi_s, ncs_s} = in_sync;

    // Only drive MISO while selected
    assign spi_miso_o = ncs_s ? 1'bz : miso_q;

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            // NCS idles high so reset does not look like a transfer
            in_meta   <= IN_WIDTH'(1);
            in_sync   <= IN_WIDTH'(1);
            miso_q    <= 1'b0;
            phase_h_o <= '0;
            phase_l_o <= '0;
        end else begin
            in_meta   <= {hall_a_i, hall_b_i, hall_c_i, enc_a_i, enc_b_i,
                          spi_sck_i, spi_mosi_i, spi_ncs_i};
            in_sync   <= in_meta;
            miso_q    <= miso;
            phase_h_o <= phase_h;
            phase_l_o <= phase_l;
        end
    end

    spi_byte_slave u_spi_slave (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .sck_i                     (sck_s),
        .mosi_i                    (mosi_s),
        .ncs_i                     (ncs_s),
        .tx_byte_i                 (tx_byte),
        .miso_o                    (miso),
        .rx_byte_o                 (rx_byte),
        .byte_done_o               (byte_done),
        .start_o                   (spi_start),
        .end_o                     (spi_end)
    );

    host_cmd_decoder u_cmd_decoder (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .rx_byte_i                 (rx_byte),
        .byte_done_i               (byte_done),
        .start_i                   (spi_start),
        .end_i                     (spi_end),
        .enc_count_i               (enc_count),
        .hall_conn_i               (hall_conn),
        .wdt_count_i               (wdt_count),
        .wdt_tripped_i             (wdt_tripped),
        .tx_byte_o                 (tx_byte),
        .duty_o                    (duty),
        .motors_en_o               (motors_en),
        .kick_o                    (kick)
    );

    motor_watchdog u_watchdog (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .kick_i                    (kick),
        .count_o                   (wdt_count),
        .tripped_o                 (wdt_tripped)
    );

    for (genvar m = 0; m < `MC_NUM_MOTORS; m++) begin : g_motor
        bldc_motor u_motor (
            .sysclk                    (sysclk),
            .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
            .en_i                      (motors_en),
            .duty_i                    (duty[m]),
            .hall_i                    ({hall_a_s[m], hall_b_s[m], hall_c_s[m]}),
            .enc_a_i                   (enc_a_s[m]),
            .enc_b_i                   (enc_b_s[m]),
            .phase_h_o                 (phase_h[3*m +: 3]),
            .phase_l_o                 (phase_l[3*m +: 3]),
            .enc_count_o               (enc_count[m]),
            .connected_o               (hall_conn[m])
        );
    end

endmodule

// File: motor_watchdog.sv
// Host watchdog with prescaler, step counter and trip flag
`include "motor_ctrl_cfg.svh"

module motor_watchdog (
    input  logic                       sysclk,
    input  logic                       watchdog_timer_reset_flag,
    input  logic                       kick_i,
    output motor_ctrl_pkg::wdt_count_t count_o,
    output logic                       tripped_o
);

    logic [`MC_WDT_PRESCALE_WIDTH-1:0] prescale_q;
    logic                              step;

    // One step each time the prescaler wraps
    assign step = (prescale_q == '1);

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag || kick_i) begin
            prescale_q <= '0;
            count_o    <= '0;
            tripped_o  <= 1'b0;
        end else begin
            prescale_q <= prescale_q + 1'b1;
            if (step) begin
                if (count_o == '1) begin
                    // Host went quiet, flag it and start over
                    tripped_o <= 1'b1;
                    count_o   <= '0;
                end else begin
                    count_o <= count_o + 1'b1;
                end
            end
        end
    end

endmodule

// File: spi_byte_slave.sv
// SPI mode-0 byte slave with oversampled SCK and NCS edge detection
`include "motor_ctrl_cfg.svh"

module spi_byte_slave (
    input  logic                      sysclk,
    input  logic                      watchdog_timer_reset_flag,
    input  logic                      sck_i,
    input  logic                      mosi_i,
    input  logic                      ncs_i,
    input  motor_ctrl_pkg::spi_byte_t tx_byte_i,
    output logic                      miso_o,
    output motor_ctrl_pkg::spi_byte_t rx_byte_o,
    output logic                      byte_done_o,
    output logic                      start_o,
    output logic                      end_o
);

    logic                      sck_d;
    logic                      ncs_d;
    logic                      load_q;
    logic                      reload_q;
    logic [2:0]                bit_cnt;
    logic                      sck_rise;
    logic                      sck_fall;
    motor_ctrl_pkg::spi_byte_t rx_shift;
    motor_ctrl_pkg::spi_byte_t tx_shift;

    assign sck_rise = sck_i & ~sck_d & ~ncs_i;
    assign sck_fall = ~sck_i & sck_d & ~ncs_i;
    assign start_o  = ncs_d & ~ncs_i;
    assign end_o    = ~ncs_d & ncs_i;
    assign miso_o   = tx_shift[`MC_BYTE_WIDTH-1];

    always_ff @(posedge sysclk) begin
        if (watchdog_timer_reset_flag) begin
            sck_d       <= 1'b0;
            ncs_d       <= 1'b1;
            load_q      <= 1'b0;
            reload_q    <= 1'b0;
            bit_cnt     <= '0;
            byte_done_o <= 1'b0;
            tx_shift    <= '1;
        end else begin
            sck_d       <= sck_i;
            ncs_d       <= ncs_i;
            // The decoder points at the status byte one cycle after start
            load_q      <= start_o;
            byte_done_o <= sck_rise && (bit_cnt == 3'd7);
            if (start_o) begin
                bit_cnt  <= '0;
                reload_q <= 1'b0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    reload_q <= 1'b1;
                end
            end
            // Next byte goes out on the falling edge that follows a full byte
            if (load_q) begin
                tx_shift <= tx_byte_i;
            end else if (sck_fall) begin
                reload_q <= 1'b0;
                tx_shift <= reload_q ? tx_byte_i : {tx_shift[`MC_BYTE_WIDTH-2:0], 1'b0};
            end
        end
    end

    // MSB first receive path
    always_ff @(posedge sysclk) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[`MC_BYTE_WIDTH-2:0], mosi_i};
            if (bit_cnt == 3'd7) begin
                rx_byte_o <= {rx_shift[`MC_BYTE_WIDTH-2:0], mosi_i};
            end
        end
    end

endmodule

// File: tb_motor_ctrl.sv
// Testbench with clock, reset, SPI host tasks, directed tests and the summary
`include "motor_ctrl_cfg.svh"

module tb_motor_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_SCK    = 10;
    // Watchdog trips after 65536 steps of 32 sysclk
    localparam int WDT_TRIP    = 65536 * 32;
    localparam int WDT_TIMEOUT = 2_200_000;
    localparam int CYCLE_LIMIT = 3_000_000;

    logic                            sysclk;
    logic                            watchdog_timer_reset_flag;
    logic [`MC_NUM_MOTORS-1:0]       hall_a;
    logic [`MC_NUM_MOTORS-1:0]       hall_b;
    logic [`MC_NUM_MOTORS-1:0]       hall_c;
    logic [`MC_NUM_MOTORS-1:0]       enc_a;
    logic [`MC_NUM_MOTORS-1:0]       enc_b;
    logic                            spi_sck;
    logic                            spi_mosi;
    logic                            spi_ncs;
    wire                             spi_miso;
    logic [3*`MC_NUM_MOTORS-1:0]     phase_h;
    logic [3*`MC_NUM_MOTORS-1:0]     phase_l;

    logic [7:0]  tx_buf [`MC_BUF_LEN];
    logic [7:0]  rx_buf [`MC_BUF_LEN];
    logic [9:0]  new_duty [`MC_NUM_MOTORS];
    logic [9:0]  exp_duty [`MC_NUM_MOTORS];
    logic [15:0] exp_enc [`MC_NUM_MOTORS];
    logic [1:0]  enc_pos [`MC_NUM_MOTORS];
    int          seed;
    int          checks = 0;
    int          errors = 0;
    int          cycle_cnt = 0;

    motor_ctrl_top uut (
        .sysclk                    (sysclk),
        .watchdog_timer_reset_flag (watchdog_timer_reset_flag),
        .hall_a_i                  (hall_a),
        .hall_b_i                  (hall_b),
        .hall_c_i                  (hall_c),
        .enc_a_i                   (enc_a),
        .enc_b_i                   (enc_b),
        .spi_sck_i                 (spi_sck),
        .spi_mosi_i                (spi_mosi),
        .spi_ncs_i                 (spi_ncs),
        .spi_miso_o                (spi_miso),
        .phase_h_o                 (phase_h),
        .phase_l_o                 (phase_l)
    );

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Hard stop in case a test loop misbehaves
    initial begin
        repeat (CYCLE_LIMIT) @(posedge sysclk);
        $display("Simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    // Returns to the drive point 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #1;
    endtask

    task automatic expect_equal(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        end
    endtask

    task automatic set_hall(input int m, input logic [2:0] code);
        hall_a[m] = code[2];
        hall_b[m] = code[1];
        hall_c[m] = code[0];
    endtask

    // Six-step table, result is {high a,b,c, low a,b,c}
    function automatic logic [5:0] commutation(input logic [2:0] hall);
        case (hall)
            3'b101:  return {3'b100, 3'b010};
            3'b100:  return {3'b100, 3'b001};
            3'b110:  return {3'b010, 3'b001};
            3'b010:  return {3'b010, 3'b100};
            3'b011:  return {3'b001, 3'b100};
            3'b001:  return {3'b001, 3'b010};
            default: return 6'b000000;
        endcase
    endfunction

    function automatic logic [7:0] status_byte(input logic trip, input logic en);
        logic [3:0] conn;
        logic [2:0] code;
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            code    = {hall_a[m], hall_b[m], hall_c[m]};
            conn[m] = (code != 3'b000) && (code != 3'b111);
        end
        return {trip, en, 2'b00, conn};
    endfunction

    task automatic load_command(input logic [7:0] cmd);
        tx_buf[0] = cmd;
        for (int i = 1; i < `MC_BUF_LEN; i++) begin
            tx_buf[i] = 8'h00;
        end
    endtask

    // Mode 0, MSB first, SCK half period of HALF_SCK sysclk
    task automatic spi_transfer(input int n_bytes);
        int b;
        int i;
        logic [7:0] rx;
        spi_ncs = 1'b0;
        for (b = 0; b < n_bytes; b++) begin
            rx = '0;
            for (i = 7; i >= 0; i--) begin
                spi_mosi = tx_buf[b][i];
                wait_cycles(HALF_SCK);
                rx[i]   = spi_miso;
                spi_sck = 1'b1;
                wait_cycles(HALF_SCK);
                spi_sck = 1'b0;
            end
            rx_buf[b] = rx;
        end
        wait_cycles(HALF_SCK);
        spi_ncs  = 1'b1;
        spi_mosi = 1'b0;
        // Room for the end-of-transfer actions
        wait_cycles(2 * HALF_SCK);
    endtask

    task automatic read_status(output logic [7:0] st);
        load_command(8'h80);
        spi_transfer(1);
        st = rx_buf[0];
    endtask

    // Low byte then the two high bits, per motor
    task automatic send_update(input int n_data);
        load_command(8'h80);
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            tx_buf[2*m+1] = new_duty[m][7:0];
            tx_buf[2*m+2] = {6'b000000, new_duty[m][9:8]};
        end
        spi_transfer(1 + n_data);
    endtask

    task automatic compare_duties(input string test);
        load_command(8'h93);
        spi_transfer(`MC_BUF_LEN);
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            expect_equal({test, " duty high"}, {6'b000000, exp_duty[m][9:8]}, rx_buf[2*m+1]);
            expect_equal({test, " duty low"}, exp_duty[m][7:0], rx_buf[2*m+2]);
        end
    endtask

    task automatic watch_gates(input int cycles, output logic [11:0] h_any,
                               output logic [11:0] l_any, output logic [11:0] l_all);
        h_any = '0;
        l_any = '0;
        l_all = '1;
        repeat (cycles) begin
            @(posedge sysclk);
            #1;
            h_any |= phase_h;
            l_any |= phase_l;
            l_all &= phase_l;
        end
    endtask

    // Gray sequence 00, 10, 11, 01 is forward with A leading B
    task automatic enc_step(input int m, input bit fwd);
        enc_pos[m] = fwd ? enc_pos[m] + 2'd1 : enc_pos[m] - 2'd1;
        enc_a[m]   = (enc_pos[m] == 2'd1) || (enc_pos[m] == 2'd2);
        enc_b[m]   = enc_pos[m][1];
        exp_enc[m] = fwd ? exp_enc[m] + 16'd1 : exp_enc[m] - 16'd1;
        wait_cycles(4);
    endtask

    task automatic after_reset();
        logic [11:0] h_any;
        logic [11:0] l_any;
        logic [11:0] l_all;
        logic [7:0]  st;
        watch_gates(100, h_any, l_any, l_all);
        expect_equal("after_reset phases", 0, h_any | l_any);
        expect_equal("after_reset miso idle", 1'bz, spi_miso);
        read_status(st);
        expect_equal("after_reset status", status_byte(1'b0, 1'b0), st);
    endtask

    task automatic duty_update();
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            new_duty[m] = $random(seed);
            exp_duty[m] = new_duty[m];
        end
        send_update(8);
        compare_duties("duty_update");
        expect_equal("duty_update enable bit", 1, rx_buf[0][6]);
        // A short update must leave the duties alone
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            new_duty[m] = $random(seed);
        end
        send_update(7);
        compare_duties("duty_update short");
    endtask

    task automatic commutation_sweep();
        logic [11:0] h_any;
        logic [11:0] l_any;
        logic [11:0] l_all;
        logic [5:0]  gates;
        string       name;
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            new_duty[m] = 10'h3ff;
            exp_duty[m] = 10'h3ff;
        end
        send_update(8);
        for (int code = 0; code < 8; code++) begin
            for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
                set_hall(m, code[2:0]);
            end
            wait_cycles(6);
            watch_gates(2000, h_any, l_any, l_all);
            gates = commutation(code[2:0]);
            for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
                name = $sformatf("commutation hall %03b motor %0d", code[2:0], m);
                expect_equal({name, " high seen"}, gates[5:3], h_any[3*m +: 3]);
                expect_equal({name, " low any"}, gates[2:0], l_any[3*m +: 3]);
                expect_equal({name, " low held"}, gates[2:0], l_all[3*m +: 3]);
            end
        end
    endtask

    task automatic encoder_counts();
        repeat (45) enc_step(1, 1'b1);
        repeat (30) enc_step(2, 1'b0);
        wait_cycles(6);
        load_command(8'h91);
        spi_transfer(`MC_BUF_LEN);
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            expect_equal($sformatf("encoder motor %0d high", m), exp_enc[m][15:8], rx_buf[2*m+1]);
            expect_equal($sformatf("encoder motor %0d low", m), exp_enc[m][7:0], rx_buf[2*m+2]);
        end
        load_command(8'h85);
        spi_transfer(`MC_BUF_LEN);
        for (int i = 1; i < `MC_BUF_LEN; i++) begin
            expect_equal($sformatf("unknown opcode byte %0d", i), 8'hAA, rx_buf[i]);
        end
    endtask

    task automatic enable_toggle();
        logic [11:0] h_any;
        logic [11:0] l_any;
        logic [11:0] l_all;
        logic [7:0]  st;
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            set_hall(m, 3'b101);
        end
        load_command(8'h30);
        spi_transfer(2);
        watch_gates(2000, h_any, l_any, l_all);
        expect_equal("enable_toggle phases off", 0, h_any | l_any);
        read_status(st);
        expect_equal("enable_toggle cleared", 0, st[6]);
        load_command(8'hB0);
        spi_transfer(2);
        read_status(st);
        expect_equal("enable_toggle set", 1, st[6]);
        watch_gates(1100, h_any, l_any, l_all);
        expect_equal("enable_toggle motor 0 low", commutation(3'b101) & 6'o07, l_all[2:0]);
    endtask

    task automatic watchdog_trip();
        logic [11:0] h_any;
        logic [11:0] l_any;
        logic [11:0] l_all;
        logic [7:0]  st;
        int          start;
        int          elapsed;
        start = cycle_cnt;
        st    = 8'h00;
        while (!st[7] && (cycle_cnt - start) < WDT_TIMEOUT) begin
            wait_cycles(4096);
            read_status(st);
        end
        elapsed = cycle_cnt - start;
        checks++;
        assert (st[7]) else begin
            errors++;
            $display("Watchdog did not trip within %0d cycles of host silence", WDT_TIMEOUT);
        end
        if (st[7]) begin
            checks++;
            assert (elapsed >= WDT_TRIP - 10000) else begin
                errors++;
                $display("Watchdog tripped too early, after %0d cycles", elapsed);
            end
            expect_equal("watchdog_trip status", status_byte(1'b1, 1'b0), st);
            watch_gates(1000, h_any, l_any, l_all);
            expect_equal("watchdog_trip phases off", 0, h_any | l_any);
            send_update(8);
            read_status(st);
            expect_equal("watchdog_trip cleared by update", 0, st[7]);
        end
    endtask

    initial begin
        seed = 32'hfc91_d2d8;
        watchdog_timer_reset_flag = 1'b1;
        enc_a    = '0;
        enc_b    = '0;
        spi_sck  = 1'b0;
        spi_mosi = 1'b0;
        spi_ncs  = 1'b1;
        for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
            exp_duty[m] = '0;
            new_duty[m] = '0;
            exp_enc[m]  = '0;
            enc_pos[m]  = '0;
        end
        // Two unplugged sensors and two valid codes
        set_hall(0, 3'b000);
        set_hall(1, 3'b111);
        set_hall(2, 3'b101);
        set_hall(3, 3'b011);
        repeat (2) @(posedge sysclk);
        #1;
        watchdog_timer_reset_flag = 1'b0;
        wait_cycles(4);

        after_reset();
        duty_update();
        commutation_sweep();
        encoder_counts();
        enable_toggle();
        watchdog_trip();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
